// File: all.f
+incdir+include
hw/spmm_data_pkg.sv
hw/spmm_ctrl_pkg.sv
hw/spmm_mem.sv
hw/spmm_row_decoder.sv
hw/spmm_sp_pe.sv
hw/spmm_wh_writer.sv
hw/spmm_top.sv
verification/spmm_tb.sv

// File: hw/spmm_ctrl_pkg.sv
package spmm_ctrl_pkg;

  // host command opcodes
  typedef enum logic [1:0] {
    OP_LOAD_H    = 2'd0,
    OP_LOAD_INFO = 2'd1,
    OP_LOAD_W    = 2'd2,
    OP_RUN       = 2'd3
  } spmm_op_e;

  // row sequencer
  typedef enum logic [1:0] {
    S_IDLE   = 2'd0,
    S_FETCH  = 2'd1,
    S_STREAM = 2'd2
  } seq_state_e;

endpackage

// File: hw/spmm_data_pkg.sv
`include "spmm_defs_defs.svh"

package spmm_data_pkg;

  // one nonzero of a sparse H row
  typedef struct packed {
    logic [`SPMM_NODE_AW-1:0]     col_idx;
    logic signed [`SPMM_DATA_W-1:0] value;
  } h_entry_t;

  // per-row descriptor
  typedef struct packed {
    logic [`SPMM_ROWLEN_W-1:0] row_length;
    logic [`SPMM_NN_W-1:0]     num_of_nodes;
    logic                      source_flag;
  } node_info_t;

  // column 3 sits in the top lane of sums
  typedef struct packed {
    logic [`SPMM_COLS-1:0][`SPMM_ACC_W-1:0] sums;
    logic [`SPMM_NN_W-1:0]                  num_of_nodes;
    logic                                   source_flag;
  } wh_t;

  // num-node record written for source rows only
  typedef logic [`SPMM_NN_W-1:0] num_node_t;

endpackage

// File: hw/spmm_mem.sv
`include "spmm_defs_defs.svh"

module spmm_mem (
  input  logic                                         clk,
  input  logic                                         rst_n,
  // host write side
  input  logic                                         h_we_i,
  input  logic [`SPMM_H_AW-1:0]                        h_waddr_i,
  input  spmm_data_pkg::h_entry_t                      h_wdata_i,
  input  logic                                         info_we_i,
  input  logic [`SPMM_INFO_AW-1:0]                     info_waddr_i,
  input  spmm_data_pkg::node_info_t                    info_wdata_i,
  input  logic                                         w_we_i,
  input  logic [`SPMM_COL_SEL_W-1:0]                   w_col_i,
  input  logic [`SPMM_NODE_AW-1:0]                     w_node_i,
  input  logic [`SPMM_DATA_W-1:0]                      w_wdata_i,
  // read side
  input  logic [`SPMM_H_AW-1:0]                        h_raddr_i,
  output spmm_data_pkg::h_entry_t                      h_rdata_o,
  input  logic [`SPMM_INFO_AW-1:0]                     info_raddr_i,
  output spmm_data_pkg::node_info_t                    info_rdata_o,
  input  logic [`SPMM_COLS-1:0][`SPMM_NODE_AW-1:0]     w_raddr_i,
  output logic [`SPMM_COLS-1:0][`SPMM_DATA_W-1:0]      w_rdata_o
);

  spmm_data_pkg::h_entry_t   h_mem    [`SPMM_H_DEPTH];
  spmm_data_pkg::node_info_t info_mem [`SPMM_INFO_DEPTH];

  // H data with one entry per nonzero
  always_ff @(posedge clk) begin
    if (h_we_i) begin
      h_mem[h_waddr_i] <= h_wdata_i;
    end
  end

  // node info with one entry per row
  always_ff @(posedge clk) begin
    if (info_we_i) begin
      info_mem[info_waddr_i] <= info_wdata_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      h_rdata_o    <= '0;
      info_rdata_o <= '0;
    end else begin
      h_rdata_o    <= h_mem[h_raddr_i];
      info_rdata_o <= info_mem[info_raddr_i];
    end
  end

  // one weight bank per column with its own read address
  for (genvar c = 0; c < `SPMM_COLS; c++) begin : g_wbank
    logic [`SPMM_DATA_W-1:0] w_mem [`SPMM_NODES];

    always_ff @(posedge clk) begin
      if (w_we_i && (w_col_i == `SPMM_COL_SEL_W'(c))) begin
        w_mem[w_node_i] <= w_wdata_i;
      end
    end

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        w_rdata_o[c] <= '0;
      end else begin
        w_rdata_o[c] <= w_mem[w_raddr_i[c]];
      end
    end
  end

endmodule

// File: hw/spmm_row_decoder.sv
`include "spmm_defs_defs.svh"

module spmm_row_decoder (
  input  logic                            clk,
  input  logic                            rst_n,
  // host command port
  input  logic                            cmd_valid_i,
  input  spmm_ctrl_pkg::spmm_op_e         cmd_op_i,
  input  logic [`SPMM_CMD_AW-1:0]         cmd_addr_i,
  input  logic [`SPMM_CMD_W-1:0]          cmd_data_i,
  // memory loads
  output logic                            h_we_o,
  output logic [`SPMM_H_AW-1:0]           h_waddr_o,
  output spmm_data_pkg::h_entry_t         h_wdata_o,
  output logic                            info_we_o,
  output logic [`SPMM_INFO_AW-1:0]        info_waddr_o,
  output spmm_data_pkg::node_info_t       info_wdata_o,
  output logic                            w_we_o,
  output logic [`SPMM_COL_SEL_W-1:0]      w_col_o,
  output logic [`SPMM_NODE_AW-1:0]        w_node_o,
  output logic [`SPMM_DATA_W-1:0]         w_wdata_o,
  // memory reads
  output logic [`SPMM_H_AW-1:0]           h_raddr_o,
  output logic [`SPMM_INFO_AW-1:0]        info_raddr_o,
  input  spmm_data_pkg::h_entry_t         h_rdata_i,
  input  spmm_data_pkg::node_info_t       info_rdata_i,
  // element stream to the PEs
  output logic                            pe_valid_o,
  output logic [`SPMM_NODE_AW-1:0]        col_idx_o,
  output logic signed [`SPMM_DATA_W-1:0]  value_o,
  output logic                            row_first_o,
  output logic                            row_last_o,
  output spmm_data_pkg::node_info_t       row_info_o,
  output logic                            busy_o,
  output logic                            run_start_o
);

  spmm_ctrl_pkg::seq_state_e    state_q;
  logic [`SPMM_H_AW-1:0]        h_addr_q;
  logic [`SPMM_INFO_AW-1:0]     info_addr_q;
  logic [`SPMM_ROWS_W-1:0]      row_cnt_q;
  logic [`SPMM_ROWS_W-1:0]      num_rows_q;
  logic [`SPMM_ROWLEN_W-1:0]    elem_cnt_q;
  logic [1:0]                   drain_q;
  logic                         cmd_take;
  logic                         streaming;
  logic                         last_row;

  // commands are dropped while a run is in progress
  assign cmd_take = cmd_valid_i && !busy_o;
  assign busy_o   = (state_q != spmm_ctrl_pkg::S_IDLE) || (drain_q != 2'd0);

  assign h_we_o       = cmd_take && (cmd_op_i == spmm_ctrl_pkg::OP_LOAD_H);
  assign h_waddr_o    = cmd_addr_i[`SPMM_H_AW-1:0];
  assign h_wdata_o    = cmd_data_i[$bits(spmm_data_pkg::h_entry_t)-1:0];
  assign info_we_o    = cmd_take && (cmd_op_i == spmm_ctrl_pkg::OP_LOAD_INFO);
  assign info_waddr_o = cmd_addr_i[`SPMM_INFO_AW-1:0];
  assign info_wdata_o = cmd_data_i[$bits(spmm_data_pkg::node_info_t)-1:0];
  // weight address is {column, node}
  assign w_we_o       = cmd_take && (cmd_op_i == spmm_ctrl_pkg::OP_LOAD_W);
  assign w_col_o      = cmd_addr_i[`SPMM_CMD_AW-1 -: `SPMM_COL_SEL_W];
  assign w_node_o     = cmd_addr_i[`SPMM_NODE_AW-1:0];
  assign w_wdata_o    = cmd_data_i[`SPMM_DATA_W-1:0];
  assign run_start_o  = cmd_take && (cmd_op_i == spmm_ctrl_pkg::OP_RUN);

  // the element on the H read port is issued straight away
  assign streaming   = (state_q == spmm_ctrl_pkg::S_STREAM);
  assign pe_valid_o  = streaming;
  assign col_idx_o   = h_rdata_i.col_idx;
  assign value_o     = h_rdata_i.value;
  assign row_info_o  = info_rdata_i;
  assign row_first_o = streaming && (elem_cnt_q == '0);
  assign row_last_o  = streaming && (elem_cnt_q == info_rdata_i.row_length - 1'b1);
  assign last_row    = (row_cnt_q == num_rows_q - 1'b1);

  // next row info is requested on the last element so it lands with the next first element
  assign h_raddr_o    = h_addr_q;
  assign info_raddr_o = row_last_o ? info_addr_q + 1'b1 : info_addr_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= spmm_ctrl_pkg::S_IDLE;
      h_addr_q    <= '0;
      info_addr_q <= '0;
      row_cnt_q   <= '0;
      num_rows_q  <= '0;
      elem_cnt_q  <= '0;
      drain_q     <= '0;
    end else begin
      // covers the two PE stages after the final element
      if (drain_q != 2'd0) begin
        drain_q <= drain_q - 2'd1;
      end
      case (state_q)
        spmm_ctrl_pkg::S_IDLE: begin
          if (run_start_o) begin
            num_rows_q  <= cmd_data_i[`SPMM_ROWS_W-1:0];
            h_addr_q    <= '0;
            info_addr_q <= '0;
            row_cnt_q   <= '0;
            elem_cnt_q  <= '0;
            state_q     <= spmm_ctrl_pkg::S_FETCH;
          end
        end
        spmm_ctrl_pkg::S_FETCH: begin
          h_addr_q <= h_addr_q + 1'b1;
          state_q  <= spmm_ctrl_pkg::S_STREAM;
        end
        spmm_ctrl_pkg::S_STREAM: begin
          h_addr_q <= h_addr_q + 1'b1;
          if (row_last_o) begin
            elem_cnt_q  <= '0;
            info_addr_q <= info_addr_q + 1'b1;
            if (last_row) begin
              state_q <= spmm_ctrl_pkg::S_IDLE;
              drain_q <= 2'd2;
            end else begin
              row_cnt_q <= row_cnt_q + 1'b1;
            end
          end else begin
            elem_cnt_q <= elem_cnt_q + 1'b1;
          end
        end
        default: state_q <= spmm_ctrl_pkg::S_IDLE;
      endcase
    end
  end

endmodule

// File: hw/spmm_sp_pe.sv
`include "spmm_defs_defs.svh"

module spmm_sp_pe (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            pe_valid_i,
  input  logic [`SPMM_NODE_AW-1:0]        col_idx_i,
  input  logic signed [`SPMM_DATA_W-1:0]  value_i,
  input  logic                            row_first_i,
  input  logic                            row_last_i,
  output logic [`SPMM_NODE_AW-1:0]        w_raddr_o,
  input  logic signed [`SPMM_DATA_W-1:0]  w_rdata_i,
  output logic signed [`SPMM_ACC_W-1:0]   sum_o,
  output logic                            sum_valid_o
);

  logic                             valid_q;
  logic                             first_q;
  logic                             last_q;
  logic                             sum_valid_q;
  logic signed [`SPMM_DATA_W-1:0]   value_q;
  logic signed [2*`SPMM_DATA_W-1:0] prod;
  logic signed [`SPMM_ACC_W-1:0]    acc_q;

  // weight comes back one cycle later, next to value_q
  assign w_raddr_o = col_idx_i;
  assign prod      = value_q * w_rdata_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q     <= 1'b0;
      first_q     <= 1'b0;
      last_q      <= 1'b0;
      sum_valid_q <= 1'b0;
    end else begin
      valid_q     <= pe_valid_i;
      first_q     <= pe_valid_i && row_first_i;
      last_q      <= pe_valid_i && row_last_i;
      sum_valid_q <= valid_q && last_q;
    end
  end

  always_ff @(posedge clk) begin
    value_q <= value_i;
    // restart on the first element of each row
    if (valid_q) begin
      if (first_q) begin
        acc_q <= `SPMM_ACC_W'(prod);
      end else begin
        acc_q <= acc_q + `SPMM_ACC_W'(prod);
      end
    end
  end

  // acc holds the row sum until the next element lands
  assign sum_o       = acc_q;
  assign sum_valid_o = sum_valid_q;

endmodule

// File: hw/spmm_top.sv
`include "spmm_defs_defs.svh"

module spmm_top (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        cmd_valid_i,
  input  spmm_ctrl_pkg::spmm_op_e     cmd_op_i,
  input  logic [`SPMM_CMD_AW-1:0]     cmd_addr_i,
  input  logic [`SPMM_CMD_W-1:0]      cmd_data_i,
  output logic                        wh_wr_o,
  output logic [`SPMM_INFO_AW-1:0]    wh_addr_o,
  output spmm_data_pkg::wh_t          wh_data_o,
  output logic                        nn_wr_o,
  output logic [`SPMM_INFO_AW-1:0]    nn_addr_o,
  output spmm_data_pkg::num_node_t    nn_data_o,
  output logic                        busy_o,
  output logic                        done_o
);

  logic                                     h_we;
  logic [`SPMM_H_AW-1:0]                    h_waddr;
  spmm_data_pkg::h_entry_t                  h_wdata;
  logic                                     info_we;
  logic [`SPMM_INFO_AW-1:0]                 info_waddr;
  spmm_data_pkg::node_info_t                info_wdata;
  logic                                     w_we;
  logic [`SPMM_COL_SEL_W-1:0]               w_col;
  logic [`SPMM_NODE_AW-1:0]                 w_node;
  logic [`SPMM_DATA_W-1:0]                  w_wdata;
  logic [`SPMM_H_AW-1:0]                    h_raddr;
  spmm_data_pkg::h_entry_t                  h_rdata;
  logic [`SPMM_INFO_AW-1:0]                 info_raddr;
  spmm_data_pkg::node_info_t                info_rdata;
  logic [`SPMM_COLS-1:0][`SPMM_NODE_AW-1:0] w_raddr;
  logic [`SPMM_COLS-1:0][`SPMM_DATA_W-1:0]  w_rdata;
  logic                                     pe_valid;
  logic [`SPMM_NODE_AW-1:0]                 col_idx;
  logic signed [`SPMM_DATA_W-1:0]           value;
  logic                                     row_first;
  logic                                     row_last;
  spmm_data_pkg::node_info_t                row_info;
  logic                                     run_start;
  logic [`SPMM_COLS-1:0][`SPMM_ACC_W-1:0]   sum;
  logic [`SPMM_COLS-1:0]                    sum_valid;

  spmm_mem spmm_mem_i (
    .clk, .rst_n,
    .h_we_i(h_we), .h_waddr_i(h_waddr), .h_wdata_i(h_wdata),
    .info_we_i(info_we), .info_waddr_i(info_waddr), .info_wdata_i(info_wdata),
    .w_we_i(w_we), .w_col_i(w_col), .w_node_i(w_node), .w_wdata_i(w_wdata),
    .h_raddr_i(h_raddr), .h_rdata_o(h_rdata),
    .info_raddr_i(info_raddr), .info_rdata_o(info_rdata),
    .w_raddr_i(w_raddr), .w_rdata_o(w_rdata)
  );

  spmm_row_decoder spmm_row_decoder_i (
    .clk, .rst_n,
    .cmd_valid_i, .cmd_op_i, .cmd_addr_i, .cmd_data_i,
    .h_we_o(h_we), .h_waddr_o(h_waddr), .h_wdata_o(h_wdata),
    .info_we_o(info_we), .info_waddr_o(info_waddr), .info_wdata_o(info_wdata),
    .w_we_o(w_we), .w_col_o(w_col), .w_node_o(w_node), .w_wdata_o(w_wdata),
    .h_raddr_o(h_raddr), .info_raddr_o(info_raddr),
    .h_rdata_i(h_rdata), .info_rdata_i(info_rdata),
    .pe_valid_o(pe_valid), .col_idx_o(col_idx), .value_o(value),
    .row_first_o(row_first), .row_last_o(row_last), .row_info_o(row_info),
    .busy_o, .run_start_o(run_start)
  );

  // one PE per weight column
  for (genvar c = 0; c < `SPMM_COLS; c++) begin : g_pe
    spmm_sp_pe spmm_sp_pe_i (
      .clk, .rst_n,
      .pe_valid_i(pe_valid), .col_idx_i(col_idx), .value_i(value),
      .row_first_i(row_first), .row_last_i(row_last),
      .w_raddr_o(w_raddr[c]), .w_rdata_i(w_rdata[c]),
      .sum_o(sum[c]), .sum_valid_o(sum_valid[c])
    );
  end

  spmm_wh_writer spmm_wh_writer_i (
    .clk, .rst_n,
    .run_start_i(run_start), .row_last_i(row_last), .row_info_i(row_info),
    .sum_i(sum), .sum_valid_i(&sum_valid), .busy_i(busy_o),
    .wh_wr_o, .wh_addr_o, .wh_data_o,
    .nn_wr_o, .nn_addr_o, .nn_data_o,
    .done_o
  );

endmodule

// File: hw/spmm_wh_writer.sv
`include "spmm_defs_defs.svh"

module spmm_wh_writer (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic                                     run_start_i,
  input  logic                                     row_last_i,
  input  spmm_data_pkg::node_info_t                row_info_i,
  input  logic [`SPMM_COLS-1:0][`SPMM_ACC_W-1:0]   sum_i,
  input  logic                                     sum_valid_i,
  input  logic                                     busy_i,
  output logic                                     wh_wr_o,
  output logic [`SPMM_INFO_AW-1:0]                 wh_addr_o,
  output spmm_data_pkg::wh_t                       wh_data_o,
  output logic                                     nn_wr_o,
  output logic [`SPMM_INFO_AW-1:0]                 nn_addr_o,
  output spmm_data_pkg::num_node_t                 nn_data_o,
  output logic                                     done_o
);

  spmm_data_pkg::node_info_t  info_d1_q;
  spmm_data_pkg::node_info_t  info_d2_q;
  logic [1:0]                 pending_q;
  logic                       wr_q;
  logic [`SPMM_INFO_AW-1:0]   wh_addr_q;
  logic [`SPMM_INFO_AW-1:0]   nn_addr_q;

  // matches the two PE stages
  always_ff @(posedge clk) begin
    info_d1_q <= row_info_i;
    info_d2_q <= info_d1_q;
  end

  always_comb begin
    wh_data_o.sums         = sum_i;
    wh_data_o.num_of_nodes = info_d2_q.num_of_nodes;
    wh_data_o.source_flag  = info_d2_q.source_flag;
  end

  assign wh_wr_o   = sum_valid_i;
  assign wh_addr_o = wh_addr_q;
  // source rows also get a num-node record
  assign nn_wr_o   = sum_valid_i && info_d2_q.source_flag;
  assign nn_addr_o = nn_addr_q;
  assign nn_data_o = info_d2_q.num_of_nodes;

  // last write done, nothing in flight, sequencer gone quiet
  assign done_o = wr_q && (pending_q == 2'd0) && !busy_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wh_addr_q <= '0;
      nn_addr_q <= '0;
      pending_q <= '0;
      wr_q      <= 1'b0;
    end else begin
      wr_q <= wh_wr_o;
      // rows issued but not yet written
      case ({row_last_i, sum_valid_i})
        2'b10:   pending_q <= pending_q + 2'd1;
        2'b01:   pending_q <= pending_q - 2'd1;
        default: pending_q <= pending_q;
      endcase
      if (run_start_i) begin
        wh_addr_q <= '0;
        nn_addr_q <= '0;
      end else begin
        if (wh_wr_o) begin
          wh_addr_q <= wh_addr_q + 1'b1;
        end
        if (nn_wr_o) begin
          nn_addr_q <= nn_addr_q + 1'b1;
        end
      end
    end
  end

endmodule

// File: include/spmm_defs_defs.svh
`ifndef SPMM_DEFS_DEFS_SVH
`define SPMM_DEFS_DEFS_SVH

// data widths
`define SPMM_DATA_W      8
`define SPMM_ACC_W       20
`define SPMM_ROWLEN_W    4
`define SPMM_NN_W        5

// array shape
`define SPMM_COLS        4
`define SPMM_NODES       16
`define SPMM_H_DEPTH     64
`define SPMM_INFO_DEPTH  16

// address widths for the depths above
`define SPMM_H_AW        6
`define SPMM_INFO_AW     4
`define SPMM_NODE_AW     4
`define SPMM_COL_SEL_W   2
`define SPMM_ROWS_W      5

// host command port
`define SPMM_CMD_AW      6
`define SPMM_CMD_W       16

`endif

// File: run.sh
#!/bin/sh
# build the testbench with Verilator and run it once
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module spmm_tb \
  -f all.f \
  -o spmm_sim

out=$(./obj_dir/spmm_sim)
echo "$out"

# the run counts as passed only if the pass line shows up
if echo "$out" | grep -qx "All tests passed!"; then
  exit 0
fi
exit 1

// File: verification/spmm_tb.sv
`include "spmm_defs_defs.svh"

module spmm_tb;

  localparam int RESET_CYCLES = 16;
  localparam int N_ROWS       = 14;
  localparam int N_ENTS       = 24;
  localparam int N_RUNS       = 3;
  // weights, H and info for both cases plus three loads dropped while busy
  localparam int LOAD_CMDS    = `SPMM_COLS * `SPMM_NODES + 16 + 6 + 8 + 8 + 3;
  localparam int NNZ_TOTAL    = 16 + 16 + 8;
  localparam int CYCLE_LIMIT  = RESET_CYCLES + LOAD_CMDS + NNZ_TOTAL + 20 * N_RUNS;

  logic                           clk;
  logic                           rst_n;
  logic                           cmd_valid;
  spmm_ctrl_pkg::spmm_op_e        cmd_op;
  logic [`SPMM_CMD_AW-1:0]        cmd_addr;
  logic [`SPMM_CMD_W-1:0]         cmd_data;
  logic                           wh_wr;
  logic [`SPMM_INFO_AW-1:0]       wh_addr;
  spmm_data_pkg::wh_t             wh_data;
  logic                           nn_wr;
  logic [`SPMM_INFO_AW-1:0]       nn_addr;
  spmm_data_pkg::num_node_t       nn_data;
  logic                           busy;
  logic                           done;

  // rows 0..5 form the mixed case and rows 6..13 hold one element each
  int tbl_len [N_ROWS] = '{1, 2, 5, 1, 3, 4, 1, 1, 1, 1, 1, 1, 1, 1};
  int tbl_nn  [N_ROWS] = '{3, 7, 12, 1, 9, 20, 2, 4, 6, 8, 10, 11, 13, 15};
  int tbl_src [N_ROWS] = '{1, 0, 1, 1, 0, 1, 0, 1, 1, 0, 1, 0, 1, 1};
  // H entries in row order
  int tbl_col [N_ENTS] = '{5, 0, 9, 1, 3, 7, 11, 15, 14, 2, 8, 13, 4, 6, 10, 12,
                           0, 15, 3, 12, 7, 9, 1, 6};
  int tbl_val [N_ENTS] = '{-128, 17, -5, 127, -64, 33, -1, 90, -77, 12, 45, -100,
                           -3, 64, -128, 55, 100, -90, 8, -128, 127, -1, 42, -66};

  // first row, row count, first entry, reload flag and busy loads of each run
  int    run_row0  [N_RUNS] = '{0, 0, 6};
  int    run_nrows [N_RUNS] = '{6, 6, 8};
  int    run_ent0  [N_RUNS] = '{0, 0, 16};
  int    run_load  [N_RUNS] = '{1, 0, 1};
  int    run_poke  [N_RUNS] = '{0, 1, 0};
  string run_name  [N_RUNS] = '{"mixed_rows", "load_while_busy", "single_rows"};

  logic signed [`SPMM_DATA_W-1:0] wt [`SPMM_COLS][`SPMM_NODES];
  spmm_data_pkg::wh_t             wh_seen [$];
  logic [`SPMM_INFO_AW-1:0]       wh_addr_seen [$];
  logic [`SPMM_INFO_AW-1:0]       nn_addr_seen [$];
  spmm_data_pkg::num_node_t       nn_data_seen [$];
  int seed;
  int cycle = 0;
  int errors = 0;
  int checks = 0;
  int tests = 0;
  int failed = 0;
  int done_cnt = 0;
  int done_cycle = 0;
  int last_wh_cycle = 0;

  spmm_top spmm_top_i (
    .clk, .rst_n,
    .cmd_valid_i(cmd_valid), .cmd_op_i(cmd_op), .cmd_addr_i(cmd_addr), .cmd_data_i(cmd_data),
    .wh_wr_o(wh_wr), .wh_addr_o(wh_addr), .wh_data_o(wh_data),
    .nn_wr_o(nn_wr), .nn_addr_o(nn_addr), .nn_data_o(nn_data),
    .busy_o(busy), .done_o(done)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle++;
    if (cycle > CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Test failures found");
      $finish;
    end
  end

  // record every write strobe and done_o pulse
  always @(negedge clk) begin
    if (wh_wr) begin
      wh_seen.push_back(wh_data);
      wh_addr_seen.push_back(wh_addr);
      last_wh_cycle = cycle;
    end
    if (nn_wr) begin
      nn_addr_seen.push_back(nn_addr);
      nn_data_seen.push_back(nn_data);
    end
    if (done) begin
      done_cnt++;
      done_cycle = cycle;
    end
  end

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    assert (exp === got) else begin
      $display("Mismatch at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic check_idle(input string tag);
    check_val({"wh_wr_o ", tag}, 0, 32'(wh_wr));
    check_val({"nn_wr_o ", tag}, 0, 32'(nn_wr));
    check_val({"busy_o ", tag}, 0, 32'(busy));
    check_val({"done_o ", tag}, 0, 32'(done));
  endtask

  task automatic send_cmd(input spmm_ctrl_pkg::spmm_op_e op, input logic [5:0] addr,
                          input logic [15:0] data);
    @(negedge clk);
    cmd_valid = 1'b1;
    cmd_op    = op;
    cmd_addr  = addr;
    cmd_data  = data;
  endtask

  task automatic idle_cmd();
    @(negedge clk);
    cmd_valid = 1'b0;
  endtask

  task automatic load_weights();
    for (int c = 0; c < `SPMM_COLS; c++) begin
      for (int n = 0; n < `SPMM_NODES; n++) begin
        wt[c][n] = 8'($random(seed));
        send_cmd(spmm_ctrl_pkg::OP_LOAD_W, 6'((c << 4) | n), 16'(wt[c][n]));
      end
    end
    idle_cmd();
  endtask

  // memory addresses restart at 0 for every case
  task automatic load_case(input int row0, input int nrows, input int ent0);
    int e;
    int r;
    e = ent0;
    for (int i = 0; i < nrows; i++) begin
      r = row0 + i;
      send_cmd(spmm_ctrl_pkg::OP_LOAD_INFO, 6'(i),
               16'((tbl_len[r] << 6) | (tbl_nn[r] << 1) | tbl_src[r]));
      for (int k = 0; k < tbl_len[r]; k++) begin
        send_cmd(spmm_ctrl_pkg::OP_LOAD_H, 6'(e - ent0),
                 16'((tbl_col[e] << 8) | (tbl_val[e] & 255)));
        e++;
      end
    end
    idle_cmd();
  endtask

  task automatic do_run(input int nrows, input int poke);
    wh_seen.delete();
    wh_addr_seen.delete();
    nn_addr_seen.delete();
    nn_data_seen.delete();
    done_cnt = 0;
    send_cmd(spmm_ctrl_pkg::OP_RUN, '0, 16'(nrows));
    idle_cmd();
    check_val("busy_o after RUN", 1, 32'(busy));
    if (poke != 0) begin
      // each of these lands while busy and has to be dropped
      send_cmd(spmm_ctrl_pkg::OP_LOAD_W, 6'h00, 16'h0055);
      check_val("busy_o during W load", 1, 32'(busy));
      send_cmd(spmm_ctrl_pkg::OP_LOAD_H, 6'h00, 16'h0f7f);
      check_val("busy_o during H load", 1, 32'(busy));
      send_cmd(spmm_ctrl_pkg::OP_LOAD_INFO, 6'h00, 16'h03ff);
      check_val("busy_o during info load", 1, 32'(busy));
      idle_cmd();
    end
    while (done !== 1'b1) begin
      @(negedge clk);
    end
    check_val("busy_o at done_o", 0, 32'(busy));
    @(negedge clk);
  endtask

  // expected sums are signed dot products of the row entries with each weight column
  task automatic check_run(input int row0, input int nrows, input int ent0);
    int e;
    int r;
    int acc;
    int nn_idx;
    spmm_data_pkg::wh_t w;
    e = ent0;
    nn_idx = 0;
    check_val("wh_wr_o count", 32'(nrows), 32'(wh_seen.size()));
    for (int i = 0; i < nrows; i++) begin
      r = row0 + i;
      if (i < wh_seen.size()) begin
        w = wh_seen[i];
        check_val($sformatf("wh_addr_o row %0d", i), 32'(i), 32'(wh_addr_seen[i]));
        for (int c = 0; c < `SPMM_COLS; c++) begin
          acc = 0;
          for (int k = 0; k < tbl_len[r]; k++) begin
            acc += tbl_val[e + k] * int'(wt[c][tbl_col[e + k]]);
          end
          check_val($sformatf("wh_data_o.sums[%0d] row %0d", c, i),
                    acc & 32'hfffff, 32'(w.sums[c]));
        end
        check_val($sformatf("wh_data_o.num_of_nodes row %0d", i),
                  32'(tbl_nn[r]), 32'(w.num_of_nodes));
        check_val($sformatf("wh_data_o.source_flag row %0d", i),
                  32'(tbl_src[r]), 32'(w.source_flag));
      end
      if (tbl_src[r] != 0) begin
        if (nn_idx < nn_data_seen.size()) begin
          check_val("nn_addr_o", 32'(nn_idx), 32'(nn_addr_seen[nn_idx]));
          check_val("nn_data_o", 32'(tbl_nn[r]), 32'(nn_data_seen[nn_idx]));
        end
        nn_idx++;
      end
      e += tbl_len[r];
    end
    check_val("nn_wr_o count", 32'(nn_idx), 32'(nn_data_seen.size()));
    check_val("done_o pulse count", 1, 32'(done_cnt));
    check_val("done_o cycle", 32'(last_wh_cycle + 1), 32'(done_cycle));
  endtask

  task automatic report_test(input string name, input int err0);
    tests++;
    if (errors == err0) begin
      $display("test %s: ok", name);
    end else begin
      failed++;
      $display("test %s: FAILED with %0d errors", name, errors - err0);
    end
  endtask

  initial begin
    int err0;
    clk       = 1'b0;
    rst_n     = 1'b0;
    cmd_valid = 1'b0;
    cmd_op    = spmm_ctrl_pkg::OP_LOAD_H;
    cmd_addr  = '0;
    cmd_data  = '0;
    seed      = 46;
    repeat (RESET_CYCLES) @(negedge clk);
    err0 = errors;
    check_idle("in reset");
    rst_n = 1'b1;
    @(negedge clk);
    check_idle("after reset");
    report_test("reset_state", err0);

    load_weights();
    for (int i = 0; i < N_RUNS; i++) begin
      err0 = errors;
      if (run_load[i] != 0) begin
        load_case(run_row0[i], run_nrows[i], run_ent0[i]);
      end
      do_run(run_nrows[i], run_poke[i]);
      check_run(run_row0[i], run_nrows[i], run_ent0[i]);
      report_test(run_name[i], err0);
    end

    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests, failed, checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
